// ==== avr_usart.f ====
+incdir+src
src/avr_usart_pkg.sv
src/usart_reg_decode.sv
src/usart_baud_gen.sv
src/usart_tx_engine.sv
src/usart_rx_engine.sv
src/usart_readout.sv
src/avr_usart.sv
sim/tb_avr_usart.sv

// ==== Bender.yml ====
package:
  name: avr_usart

sources:
  - include_dirs:
      - src
    files:
      - src/avr_usart_pkg.sv
      - src/usart_reg_decode.sv
      - src/usart_baud_gen.sv
      - src/usart_tx_engine.sv
      - src/usart_rx_engine.sv
      - src/usart_readout.sv
      - src/avr_usart.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/tb_avr_usart.sv

// ==== sim/tb_avr_usart.sv ====
`timescale 1ns/100ps
`include "avr_usart_cfg.svh"

module tb_avr_usart;
	import avr_usart_pkg::*;

	localparam int N_TX     = 10;
	localparam int N_RX     = 14;
	localparam int N_FRAMES = N_TX + N_RX + 3 + 2; // Plus FIFO and interrupt frames
	localparam int MAX_BIT  = `USART_OVERSAMPLE * 4; // UBRR at most 3
	localparam int LIMIT    = N_FRAMES * 12 * MAX_BIT + 2000;

	logic      cp2;
	logic      ireset;
	ram_addr_t ram_addr;
	logic      ramre;
	logic      ramwe;
	data_t     dbus_wr;
	data_t     dbus_rd;
	logic      out_en;
	logic      rxd;
	logic      txd;
	logic      rxen;
	logic      txen;
	logic      rxc_irq;
	logic      txc_irq;
	logic      udre_irq;
	irq_vec_t  irqack_addr;
	logic      irqack;
	integer    seed;
	int        err_cnt = 0;
	int        cycle_cnt = 0;

	avr_usart avr_usart_inst (
		.cp2          (cp2),
		.ireset       (ireset),
		.ram_addr_i   (ram_addr),
		.ramre_i      (ramre),
		.ramwe_i      (ramwe),
		.dbus_i       (dbus_wr),
		.dbus_o       (dbus_rd),
		.out_en_o     (out_en),
		.rxd_i        (rxd),
		.txd_o        (txd),
		.rxen_o       (rxen),
		.txen_o       (txen),
		.rxc_irq_o    (rxc_irq),
		.txc_irq_o    (txc_irq),
		.udre_irq_o   (udre_irq),
		.irqack_addr_i(irqack_addr),
		.irqack_i     (irqack)
	);

	initial begin
		cp2 = 1'b0;
		forever #10 cp2 = ~cp2;
	end

	task automatic fail_run(input string msg);
		err_cnt++;
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	always @(posedge cp2) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == LIMIT)
			fail_run($sformatf("Run timed out after %0d cycles without finishing", LIMIT));
	end

	task automatic check_byte(input string name, input data_t exp, input data_t act);
		if (act !== exp)
			fail_run($sformatf("Error in %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_run($sformatf("Error in %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_entry(input string name, input rx_entry_t exp, input rx_entry_t act);
		if (act !== exp)
			fail_run($sformatf(
				"Error in %s: expected fe=%b pe=%b data=%h, actual fe=%b pe=%b data=%h",
				name, exp.fe, exp.pe, exp.data, act.fe, act.pe, act.data));
	endtask

	// Bits in use for the UCSZ code in UCSRC bits 2:1
	function automatic data_t data_mask(input data_t c);
		data_t m;
		m = '0;
		for (int i = 0; i < 5 + c[2:1]; i++)
			m[i] = 1'b1;
		return m;
	endfunction

	// Line image of one frame with bit 0 first and stop bits and padding high
	function automatic logic [11:0] frame_image(input data_t d, input data_t c);
		logic [11:0] f;
		logic        p;
		int          n;
		n = 5 + c[2:1];
		p = c[4]; // Odd parity starts inverted
		f = '1;
		f[0] = 1'b0;
		for (int i = 0; i < n; i++) begin
			f[i + 1] = d[i];
			p = p ^ d[i];
		end
		if (c[5])
			f[n + 1] = p;
		return f;
	endfunction

	function automatic rx_entry_t expected_entry(input data_t d, input data_t c,
		input logic bad_par, input logic bad_stop);
		rx_entry_t e;
		e.data = d & data_mask(c);
		e.fe   = bad_stop;
		e.pe   = c[5] && bad_par;
		return e;
	endfunction

	task automatic bus_write(input ram_addr_t a, input data_t v);
		@(posedge cp2);
		ram_addr <= a;
		dbus_wr  <= v;
		ramwe    <= 1'b1;
		@(posedge cp2);
		ramwe <= 1'b0;
	endtask

	// Read data is combinational and sampled mid-cycle
	task automatic bus_read(input ram_addr_t a, output data_t v, output logic oe);
		@(posedge cp2);
		ram_addr <= a;
		ramre    <= 1'b1;
		@(negedge cp2);
		v  = dbus_rd;
		oe = out_en;
		@(posedge cp2);
		ramre <= 1'b0;
	endtask

	task automatic configure(input data_t c, input baud_div_t u);
		bus_write(`USART_UBRRH_ADDR, data_t'(u >> 8));
		bus_write(`USART_UBRRL_ADDR, u[7:0]);
		bus_write(`USART_UCSRC_ADDR, c);
	endtask

	task automatic acknowledge(input irq_vec_t vec);
		@(posedge cp2);
		irqack_addr <= vec;
		irqack      <= 1'b1;
		@(posedge cp2);
		irqack <= 1'b0;
	endtask

	task automatic send_and_check_tx(input data_t d, input data_t c, input baud_div_t u);
		logic [11:0] f;
		int          len;
		int          t;
		int          lat;
		data_t       sr;
		logic        oe;
		t   = `USART_OVERSAMPLE * (u + 1);
		len = 2 + 5 + c[2:1] + c[5] + c[3];
		f   = frame_image(d, c);
		configure(c, u);
		bus_write(`USART_UDR_ADDR, d);
		lat = 0;
		@(negedge cp2);
		while (txd !== 1'b0) begin
			lat++;
			if (lat > 3)
				fail_run("Start bit did not begin within 3 cycles of the UDR write");
			else
				@(negedge cp2);
		end
		repeat (t / 2) @(negedge cp2); // Middle of the start bit
		for (int i = 0; i < len; i++) begin
			if (i > 0)
				repeat (t) @(negedge cp2);
			check_bit($sformatf("tx frame bit %0d", i), f[i], txd);
		end
		do
			bus_read(`USART_UCSRA_ADDR, sr, oe);
		while (!sr[6]);
		check_bit("tx UDRE after frame", 1'b1, sr[5]);
		bus_write(`USART_UCSRA_ADDR, 8'h40);
		bus_read(`USART_UCSRA_ADDR, sr, oe);
		check_bit("tx TXC cleared by write", 1'b0, sr[6]);
	endtask

	task automatic drive_rx_frame(input data_t d, input data_t c, input baud_div_t u,
		input logic bad_par, input logic bad_stop);
		logic [11:0] f;
		int          n;
		int          len;
		int          t;
		t   = `USART_OVERSAMPLE * (u + 1);
		n   = 5 + c[2:1];
		len = 2 + n + c[5]; // Single stop bit on the line
		f   = frame_image(d, c);
		if (c[5] && bad_par)
			f[n + 1] = !f[n + 1];
		if (bad_stop)
			f[n + 1 + c[5]] = 1'b0;
		for (int i = 0; i < len; i++) begin
			@(posedge cp2);
			rxd <= f[i];
			repeat (t - 1) @(posedge cp2);
		end
		@(posedge cp2);
		rxd <= 1'b1; // Idle gap before the next start edge
		repeat (3) @(posedge cp2);
	endtask

	task automatic read_entry(output rx_entry_t e);
		data_t sr;
		data_t d;
		logic  oe;
		do
			bus_read(`USART_UCSRA_ADDR, sr, oe);
		while (!sr[7]);
		bus_read(`USART_UDR_ADDR, d, oe);
		e.fe   = sr[4];
		e.pe   = sr[2];
		e.data = d;
	endtask

	task automatic read_reset_values();
		data_t v;
		logic  oe;
		@(negedge cp2);
		check_byte("reset outputs", 8'h00,
			{1'b0, txd, out_en, rxen, txen, rxc_irq, txc_irq, udre_irq});
		bus_read(`USART_UCSRA_ADDR, v, oe);
		check_byte("reset UCSRA", 8'h20, v);
		bus_read(`USART_UCSRB_ADDR, v, oe);
		check_byte("reset UCSRB", 8'h00, v);
		bus_read(`USART_UCSRC_ADDR, v, oe);
		check_byte("reset UCSRC", 8'h06, v);
		bus_read(`USART_UBRRL_ADDR, v, oe);
		check_byte("reset UBRRL", 8'h00, v);
	endtask

	task automatic readback_registers();
		data_t     v;
		data_t     r;
		data_t     h;
		data_t     l;
		baud_div_t ubrr_m;
		ram_addr_t a;
		logic      oe;
		ubrr_m = '0;
		repeat (8) begin
			v = data_t'($random(seed));
			bus_write(`USART_UCSRB_ADDR, v);
			bus_read(`USART_UCSRB_ADDR, r, oe);
			check_byte("UCSRB readback", v & 8'hF8, r);
			check_bit("UCSRB out_en", 1'b1, oe);
			check_bit("rxen pin", v[4], rxen);
			check_bit("txen pin", v[3], txen);
			v = data_t'($random(seed));
			bus_write(`USART_UCSRC_ADDR, v);
			bus_read(`USART_UCSRC_ADDR, r, oe);
			check_byte("UCSRC readback", v & 8'h3E, r);
			h = data_t'($random(seed));
			l = data_t'($random(seed));
			bus_write(`USART_UBRRH_ADDR, h);
			bus_read(`USART_UBRRH_ADDR, r, oe);
			check_byte("UBRRH staged", data_t'(ubrr_m >> 8), r); // Not visible before UBRRL
			bus_write(`USART_UBRRL_ADDR, l);
			ubrr_m = {h[3:0], l};
			bus_read(`USART_UBRRH_ADDR, r, oe);
			check_byte("UBRRH readback", h & 8'h0F, r);
			bus_read(`USART_UBRRL_ADDR, r, oe);
			check_byte("UBRRL readback", l, r);
			a = ram_addr_t'($random(seed));
			if (a inside {`USART_UDR_ADDR, `USART_UCSRA_ADDR, `USART_UCSRB_ADDR,
				`USART_UCSRC_ADDR, `USART_UBRRH_ADDR, `USART_UBRRL_ADDR})
				a = 12'h0C3;
			bus_read(a, r, oe);
			check_bit("unused address out_en", 1'b0, oe);
		end
		bus_write(`USART_UCSRB_ADDR, 8'h18); // RXEN and TXEN
	endtask

	task automatic receive_frames();
		data_t     d;
		data_t     c;
		data_t     r;
		baud_div_t u;
		logic      bp;
		logic      bs;
		logic      oe;
		rx_entry_t e;
		repeat (N_RX) begin
			d  = data_t'($random(seed));
			c  = data_t'($random(seed));
			u  = baud_div_t'($random(seed)) & 12'd3;
			bp = ($random(seed) & 3) == 0;
			bs = ($random(seed) & 3) == 0;
			configure(c, u);
			drive_rx_frame(d, c, u, bp, bs);
			read_entry(e);
			check_entry("rx frame", expected_entry(d, c, bp, bs), e);
			bus_read(`USART_UCSRA_ADDR, r, oe);
			check_bit("rx RXC after pop", 1'b0, r[7]);
		end
	endtask

	task automatic overflow_fifo();
		data_t     d [3];
		data_t     c;
		data_t     r;
		baud_div_t u;
		logic      oe;
		rx_entry_t e;
		c = data_t'($random(seed));
		u = baud_div_t'($random(seed)) & 12'd3;
		configure(c, u);
		for (int k = 0; k < 3; k++) begin
			d[k] = data_t'($random(seed));
			drive_rx_frame(d[k], c, u, 1'b0, 1'b0);
		end
		read_entry(e);
		check_entry("fifo entry 0", expected_entry(d[0], c, 1'b0, 1'b0), e);
		read_entry(e);
		check_entry("fifo entry 1", expected_entry(d[1], c, 1'b0, 1'b0), e);
		bus_read(`USART_UCSRA_ADDR, r, oe);
		check_bit("fifo third frame dropped", 1'b0, r[7]);
	endtask

	task automatic exercise_interrupts();
		data_t r;
		logic  oe;
		bus_write(`USART_UCSRB_ADDR, 8'hF8); // All enables on
		configure(8'h06, 12'd0);
		@(negedge cp2);
		check_bit("udre irq while empty", 1'b1, udre_irq);
		check_bit("txc irq idle", 1'b0, txc_irq);
		check_bit("rxc irq idle", 1'b0, rxc_irq);
		bus_write(`USART_UDR_ADDR, data_t'($random(seed)));
		@(negedge cp2);
		check_bit("udre irq with buffer full", 1'b0, udre_irq);
		while (txc_irq !== 1'b1)
			@(negedge cp2);
		check_bit("udre irq after frame", 1'b1, udre_irq);
		acknowledge(`USART_RXC_VEC);
		@(negedge cp2);
		check_bit("txc irq after other ack", 1'b1, txc_irq);
		acknowledge(`USART_TXC_VEC);
		@(negedge cp2);
		check_bit("txc irq after ack", 1'b0, txc_irq);
		drive_rx_frame(data_t'($random(seed)), 8'h06, 12'd0, 1'b0, 1'b0);
		do
			bus_read(`USART_UCSRA_ADDR, r, oe);
		while (!r[7]);
		@(negedge cp2);
		check_bit("rxc irq with data", 1'b1, rxc_irq);
		bus_write(`USART_UCSRB_ADDR, 8'hE8);
		repeat (2) @(negedge cp2); // Flush lands one edge after RXEN falls
		check_bit("rxen pin cleared", 1'b0, rxen);
		check_bit("rxc irq after flush", 1'b0, rxc_irq);
		bus_write(`USART_UCSRB_ADDR, 8'hF8);
		bus_read(`USART_UCSRA_ADDR, r, oe);
		check_bit("RXC after flush", 1'b0, r[7]);
	endtask

	initial begin
		seed        = 32'h6091_336f;
		ireset      = 1'b0;
		ram_addr    = '0;
		ramre       = 1'b0;
		ramwe       = 1'b0;
		dbus_wr     = '0;
		rxd         = 1'b1; // Line idles high
		irqack      = 1'b0;
		irqack_addr = '0;
		repeat (16) @(posedge cp2);
		ireset <= 1'b1;
		read_reset_values();
		readback_registers();
		repeat (N_TX) begin
			send_and_check_tx(data_t'($random(seed)), data_t'($random(seed)),
				baud_div_t'($random(seed)) & 12'd3);
		end
		receive_frames();
		overflow_fifo();
		exercise_interrupts();
		if (err_cnt == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== src/avr_usart.sv ====
`timescale 1ns/100ps

module avr_usart (
	input  logic                     cp2,
	input  logic                     ireset,
	input  avr_usart_pkg::ram_addr_t ram_addr_i,
	input  logic                     ramre_i,
	input  logic                     ramwe_i,
	input  avr_usart_pkg::data_t     dbus_i,
	output avr_usart_pkg::data_t     dbus_o,
	output logic                     out_en_o,
	input  logic                     rxd_i,
	output logic                     txd_o,
	output logic                     rxen_o,
	output logic                     txen_o,
	output logic                     rxc_irq_o,
	output logic                     txc_irq_o,
	output logic                     udre_irq_o,
	input  avr_usart_pkg::irq_vec_t  irqack_addr_i,
	input  logic                     irqack_i
);
	import avr_usart_pkg::*;

	frame_cfg_t frame_cfg;
	baud_div_t  baud_div;
	irq_en_t    irq_en;
	reg_sel_e   reg_sel;
	logic       txc_flag;
	logic       tx_push;
	data_t      tx_data;
	logic       rx_pop;
	logic       tx_done;
	logic       udre;
	rx_entry_t  rx_head;
	logic       rx_avail;

	usart_reg_decode decode_inst (
		.cp2          (cp2),
		.ireset       (ireset),
		.ram_addr_i   (ram_addr_i),
		.ramre_i      (ramre_i),
		.ramwe_i      (ramwe_i),
		.dbus_i       (dbus_i),
		.irqack_addr_i(irqack_addr_i),
		.irqack_i     (irqack_i),
		.tx_done_i    (tx_done),
		.frame_cfg_o  (frame_cfg),
		.baud_div_o   (baud_div),
		.irq_en_o     (irq_en),
		.reg_sel_o    (reg_sel),
		.txc_flag_o   (txc_flag),
		.tx_push_o    (tx_push),
		.tx_data_o    (tx_data),
		.rx_pop_o     (rx_pop)
	);

	usart_tx_engine tx_inst (
		.cp2        (cp2),
		.ireset     (ireset),
		.frame_cfg_i(frame_cfg),
		.baud_div_i (baud_div),
		.tx_push_i  (tx_push),
		.tx_data_i  (tx_data),
		.txd_o      (txd_o),
		.udre_o     (udre),
		.tx_done_o  (tx_done)
	);

	usart_rx_engine rx_inst (
		.cp2        (cp2),
		.ireset     (ireset),
		.frame_cfg_i(frame_cfg),
		.baud_div_i (baud_div),
		.rxd_i      (rxd_i),
		.rx_pop_i   (rx_pop),
		.rx_head_o  (rx_head),
		.rx_avail_o (rx_avail)
	);

	usart_readout readout_inst (
		.reg_sel_i  (reg_sel),
		.ramre_i    (ramre_i),
		.frame_cfg_i(frame_cfg),
		.irq_en_i   (irq_en),
		.baud_div_i (baud_div),
		.txc_flag_i (txc_flag),
		.udre_i     (udre),
		.rx_avail_i (rx_avail),
		.rx_head_i  (rx_head),
		.dbus_o     (dbus_o),
		.out_en_o   (out_en_o),
		.rxc_irq_o  (rxc_irq_o),
		.txc_irq_o  (txc_irq_o),
		.udre_irq_o (udre_irq_o)
	);

	assign rxen_o = frame_cfg.rx_en;
	assign txen_o = frame_cfg.tx_en;

endmodule

// ==== src/usart_readout.sv ====
`timescale 1ns/100ps
`include "avr_usart_cfg.svh"

module usart_readout (
	input  avr_usart_pkg::reg_sel_e   reg_sel_i,
	input  logic                      ramre_i,
	input  avr_usart_pkg::frame_cfg_t frame_cfg_i,
	input  avr_usart_pkg::irq_en_t    irq_en_i,
	input  avr_usart_pkg::baud_div_t  baud_div_i,
	input  logic                      txc_flag_i,
	input  logic                      udre_i,
	input  logic                      rx_avail_i,
	input  avr_usart_pkg::rx_entry_t  rx_head_i,
	output avr_usart_pkg::data_t      dbus_o,
	output logic                      out_en_o,
	output logic                      rxc_irq_o,
	output logic                      txc_irq_o,
	output logic                      udre_irq_o
);
	import avr_usart_pkg::*;

	data_t ucsra;
	data_t ucsrb;
	data_t ucsrc;

	// Dropped bits read as zero
	assign ucsra = {rx_avail_i, txc_flag_i, udre_i, rx_head_i.fe, 1'b0, rx_head_i.pe, 2'b00};
	assign ucsrb = {irq_en_i.rxc, irq_en_i.txc, irq_en_i.udre,
		frame_cfg_i.rx_en, frame_cfg_i.tx_en, 3'b000};
	assign ucsrc = {2'b00, frame_cfg_i.parity, frame_cfg_i.two_stop, frame_cfg_i.char_size, 1'b0};

	always_comb begin
		case (reg_sel_i)
			SEL_UDR:   dbus_o = rx_head_i.data;
			SEL_UCSRA: dbus_o = ucsra;
			SEL_UCSRB: dbus_o = ucsrb;
			SEL_UCSRC: dbus_o = ucsrc;
			SEL_UBRRH: dbus_o = data_t'(baud_div_i >> `USART_DATA_W);
			SEL_UBRRL: dbus_o = baud_div_i[`USART_DATA_W-1:0];
			default:   dbus_o = '0;
		endcase
	end

	assign out_en_o   = ramre_i && (reg_sel_i != SEL_NONE);
	assign rxc_irq_o  = irq_en_i.rxc && rx_avail_i;
	assign txc_irq_o  = irq_en_i.txc && txc_flag_i;
	assign udre_irq_o = irq_en_i.udre && udre_i;

endmodule

// ==== src/usart_rx_engine.sv ====
`timescale 1ns/100ps
`include "avr_usart_cfg.svh"

module usart_rx_engine (
	input  logic                      cp2,
	input  logic                      ireset,
	input  avr_usart_pkg::frame_cfg_t frame_cfg_i,
	input  avr_usart_pkg::baud_div_t  baud_div_i,
	input  logic                      rxd_i,
	input  logic                      rx_pop_i,
	output avr_usart_pkg::rx_entry_t  rx_head_o,
	output logic                      rx_avail_o
);
	import avr_usart_pkg::*;

	localparam logic [3:0] LAST_TICK  = 4'(`USART_OVERSAMPLE - 1);
	localparam logic [3:0] VOTE_FIRST = 4'(`USART_OVERSAMPLE / 2 - 1); // Ticks 7, 8 and 9
	localparam logic [3:0] VOTE_LAST  = VOTE_FIRST + 4'd2;
	localparam int PTR_W = $clog2(`USART_RX_DEPTH);
	localparam int CNT_W = $clog2(`USART_RX_DEPTH + 1);

	rx_state_e  state_q;
	logic       rxd_meta_q;
	logic       rxd_sync_q;
	logic       rxd_prev_q;
	logic       tick;
	logic       restart;
	logic [3:0] tick_cnt_q;
	logic [3:0] bit_idx_q;
	logic [3:0] n_bits;
	logic [3:0] stop_idx;
	logic [1:0] vote_q;
	logic       voted;
	logic       par_en;
	data_t      mask;
	logic [`USART_DATA_W+1:0] bits_q; // Data, parity and stop
	logic       frame_done_q;
	rx_entry_t  entry;
	rx_entry_t  fifo_q [`USART_RX_DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic       push;
	logic       pop;

	usart_baud_gen baud_inst (
		.cp2       (cp2),
		.ireset    (ireset),
		.restart_i (restart),
		.baud_div_i(baud_div_i),
		.tick_o    (tick)
	);

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			rxd_meta_q <= 1'b1;
			rxd_sync_q <= 1'b1;
			rxd_prev_q <= 1'b1;
		end else begin
			rxd_meta_q <= rxd_i;
			rxd_sync_q <= rxd_meta_q;
			rxd_prev_q <= rxd_sync_q; // Edge detect
		end
	end

	assign restart = (state_q == RX_IDLE) && frame_cfg_i.rx_en && rxd_prev_q && !rxd_sync_q;
	assign voted = (vote_q[1] & vote_q[0]) | (vote_q[1] & rxd_sync_q) | (vote_q[0] & rxd_sync_q);

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			state_q      <= RX_IDLE;
			tick_cnt_q   <= '0;
			bit_idx_q    <= '0;
			vote_q       <= '0;
			frame_done_q <= 1'b0;
		end else begin
			frame_done_q <= 1'b0;
			if (!frame_cfg_i.rx_en) begin
				state_q <= RX_IDLE;
			end else if (restart) begin
				state_q    <= RX_START;
				tick_cnt_q <= '0;
			end else if ((state_q != RX_IDLE) && tick) begin
				tick_cnt_q <= tick_cnt_q + 4'd1;
				if ((tick_cnt_q == VOTE_FIRST) || (tick_cnt_q == VOTE_FIRST + 4'd1))
					vote_q <= {vote_q[0], rxd_sync_q};
				if (tick_cnt_q == VOTE_LAST) begin
					if (state_q == RX_START) begin
						if (voted)
							state_q <= RX_IDLE; // Glitch, no start bit
					end else begin
						bit_idx_q <= bit_idx_q + 4'd1;
						if (bit_idx_q == stop_idx) begin
							state_q      <= RX_IDLE; // Only the first stop bit matters
							frame_done_q <= 1'b1;
						end
					end
				end
				if ((state_q == RX_START) && (tick_cnt_q == LAST_TICK)) begin
					state_q   <= RX_DATA;
					bit_idx_q <= '0;
				end
			end
		end
	end

	always_ff @(posedge cp2) begin
		if ((state_q == RX_DATA) && tick && (tick_cnt_q == VOTE_LAST))
			bits_q[bit_idx_q] <= voted;
	end

	always_comb begin
		n_bits     = {2'b00, frame_cfg_i.char_size} + 4'd5;
		par_en     = (frame_cfg_i.parity == PAR_EVEN) || (frame_cfg_i.parity == PAR_ODD);
		stop_idx   = n_bits + {3'b000, par_en};
		mask       = data_t'(8'hFF >> (2'd3 - frame_cfg_i.char_size));
		entry.data = bits_q[`USART_DATA_W-1:0] & mask;
		entry.fe   = !bits_q[stop_idx];
		entry.pe   = par_en &&
			(bits_q[n_bits] != ((^entry.data) ^ (frame_cfg_i.parity == PAR_ODD)));
	end

	// Frames arriving at a full FIFO are lost
	assign push = frame_done_q && (count_q != CNT_W'(`USART_RX_DEPTH));
	assign pop  = rx_pop_i && (count_q != '0);

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else if (!frame_cfg_i.rx_en) begin
			wr_ptr_q <= '0; // Flush while disabled
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push)
				wr_ptr_q <= wr_ptr_q + 1'b1; // Depth is a power of two
			if (pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			if (push && !pop)
				count_q <= count_q + 1'b1;
			else if (pop && !push)
				count_q <= count_q - 1'b1;
		end
	end

	always_ff @(posedge cp2) begin
		if (push)
			fifo_q[wr_ptr_q] <= entry;
	end

	assign rx_avail_o = (count_q != '0);
	assign rx_head_o  = rx_avail_o ? fifo_q[rd_ptr_q] : '0;

	assert property (@(posedge cp2) disable iff (!ireset) count_q <= CNT_W'(`USART_RX_DEPTH))
		else $error("Receive FIFO count above depth");

endmodule

// ==== src/usart_tx_engine.sv ====
`timescale 1ns/100ps
`include "avr_usart_cfg.svh"

module usart_tx_engine (
	input  logic                      cp2,
	input  logic                      ireset,
	input  avr_usart_pkg::frame_cfg_t frame_cfg_i,
	input  avr_usart_pkg::baud_div_t  baud_div_i,
	input  logic                      tx_push_i,
	input  avr_usart_pkg::data_t      tx_data_i,
	output logic                      txd_o,
	output logic                      udre_o,
	output logic                      tx_done_o
);
	import avr_usart_pkg::*;

	localparam logic [3:0] LAST_TICK = 4'(`USART_OVERSAMPLE - 1);
	localparam int FRAME_W = `USART_DATA_W + 4; // Start, data, parity, two stops

	tx_state_e          state_q;
	logic               buf_full_q;
	data_t              buf_q;
	logic [FRAME_W-1:0] shreg_q;
	logic [FRAME_W-1:0] frame;
	logic [3:0]         tick_cnt_q;
	logic [3:0]         bit_cnt_q;
	logic [3:0]         n_bits;
	logic [3:0]         frame_bits;
	data_t              mask;
	logic               par_en;
	logic               par_bit;
	logic               tick;
	logic               bit_end;
	logic               load;
	logic               done_q;

	usart_baud_gen baud_inst (
		.cp2       (cp2),
		.ireset    (ireset),
		.restart_i (load),
		.baud_div_i(baud_div_i),
		.tick_o    (tick)
	);

	// Frame image with the LSB going out first
	always_comb begin
		n_bits  = {2'b00, frame_cfg_i.char_size} + 4'd5;
		mask    = data_t'(8'hFF >> (2'd3 - frame_cfg_i.char_size));
		par_en  = (frame_cfg_i.parity == PAR_EVEN) || (frame_cfg_i.parity == PAR_ODD);
		par_bit = (^(buf_q & mask)) ^ (frame_cfg_i.parity == PAR_ODD);
		frame    = '1;
		frame[0] = 1'b0; // Start bit
		for (int i = 0; i < `USART_DATA_W; i++) begin
			if (i < n_bits)
				frame[i + 1] = buf_q[i];
		end
		if (par_en)
			frame[n_bits + 1] = par_bit;
		frame_bits = n_bits + 4'd2 + {3'b000, par_en} + {3'b000, frame_cfg_i.two_stop};
	end

	assign bit_end = (state_q == TX_SHIFT) && tick && (tick_cnt_q == LAST_TICK);
	// Next frame follows straight on if the buffer is already full
	assign load = buf_full_q && ((state_q == TX_IDLE) || (bit_end && (bit_cnt_q == 4'd1)));

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			state_q    <= TX_IDLE;
			buf_full_q <= 1'b0;
			tick_cnt_q <= '0;
			bit_cnt_q  <= '0;
			done_q     <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (tx_push_i && !buf_full_q)
				buf_full_q <= 1'b1; // Write into a full buffer is dropped
			else if (load)
				buf_full_q <= 1'b0;
			if (load) begin
				state_q    <= TX_SHIFT;
				tick_cnt_q <= '0;
				bit_cnt_q  <= frame_bits;
			end else if ((state_q == TX_SHIFT) && tick) begin
				tick_cnt_q <= tick_cnt_q + 4'd1;
				if (bit_end) begin
					bit_cnt_q <= bit_cnt_q - 4'd1;
					if (bit_cnt_q == 4'd1) begin
						state_q <= TX_IDLE;
						done_q  <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge cp2) begin
		if (tx_push_i && !buf_full_q)
			buf_q <= tx_data_i;
		if (load)
			shreg_q <= frame;
		else if (bit_end)
			shreg_q <= {1'b1, shreg_q[FRAME_W-1:1]};
	end

	assign txd_o     = (state_q == TX_SHIFT) ? shreg_q[0] : frame_cfg_i.tx_en;
	assign udre_o    = !buf_full_q;
	assign tx_done_o = done_q;

	// Every frame ends on a high stop bit
	assert property (@(posedge cp2) disable iff (!ireset)
		((state_q == TX_SHIFT) && (bit_cnt_q == 4'd1)) |-> txd_o)
		else $error("TXD low in the last bit of a frame");

endmodule

// ==== src/usart_baud_gen.sv ====
`timescale 1ns/100ps

module usart_baud_gen (
	input  logic                     cp2,
	input  logic                     ireset,
	input  logic                     restart_i,
	input  avr_usart_pkg::baud_div_t baud_div_i,
	output logic                     tick_o
);
	import avr_usart_pkg::*;

	baud_div_t cnt_q;

	// Down-counter, one tick per UBRR+1 cycles
	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset)
			cnt_q <= '0;
		else if (restart_i || (cnt_q == '0))
			cnt_q <= baud_div_i;
		else
			cnt_q <= cnt_q - 1'b1;
	end

	assign tick_o = (cnt_q == '0) && !restart_i; // Phase restarts with the frame

endmodule

// ==== src/usart_reg_decode.sv ====
`timescale 1ns/100ps
`include "avr_usart_cfg.svh"

module usart_reg_decode (
	input  logic                      cp2,
	input  logic                      ireset,
	input  avr_usart_pkg::ram_addr_t  ram_addr_i,
	input  logic                      ramre_i,
	input  logic                      ramwe_i,
	input  avr_usart_pkg::data_t      dbus_i,
	input  avr_usart_pkg::irq_vec_t   irqack_addr_i,
	input  logic                      irqack_i,
	input  logic                      tx_done_i,
	output avr_usart_pkg::frame_cfg_t frame_cfg_o,
	output avr_usart_pkg::baud_div_t  baud_div_o,
	output avr_usart_pkg::irq_en_t    irq_en_o,
	output avr_usart_pkg::reg_sel_e   reg_sel_o,
	output logic                      txc_flag_o,
	output logic                      tx_push_o,
	output avr_usart_pkg::data_t      tx_data_o,
	output logic                      rx_pop_o
);
	import avr_usart_pkg::*;

	frame_cfg_t frame_cfg_q;
	irq_en_t    irq_en_q;
	baud_div_t  ubrr_q;
	logic [`USART_BAUD_W-`USART_DATA_W-1:0] ubrrh_stage_q; // High nibble waits for UBRRL
	logic       txc_q;
	logic       txc_clr;
	reg_sel_e   sel;

	always_comb begin
		case (ram_addr_i)
			`USART_UDR_ADDR:   sel = SEL_UDR;
			`USART_UCSRA_ADDR: sel = SEL_UCSRA;
			`USART_UCSRB_ADDR: sel = SEL_UCSRB;
			`USART_UCSRC_ADDR: sel = SEL_UCSRC;
			`USART_UBRRH_ADDR: sel = SEL_UBRRH;
			`USART_UBRRL_ADDR: sel = SEL_UBRRL;
			default:           sel = SEL_NONE;
		endcase
	end

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			frame_cfg_q.rx_en     <= 1'b0;
			frame_cfg_q.tx_en     <= 1'b0;
			frame_cfg_q.char_size <= 2'b11; // UCSRC reads 06
			frame_cfg_q.parity    <= PAR_NONE;
			frame_cfg_q.two_stop  <= 1'b0;
			irq_en_q              <= '0;
			ubrr_q                <= '0;
			ubrrh_stage_q         <= '0;
		end else if (ramwe_i) begin
			case (sel)
				SEL_UCSRB: begin
					irq_en_q.rxc      <= dbus_i[7];
					irq_en_q.txc      <= dbus_i[6];
					irq_en_q.udre     <= dbus_i[5];
					frame_cfg_q.rx_en <= dbus_i[4];
					frame_cfg_q.tx_en <= dbus_i[3];
				end
				SEL_UCSRC: begin
					frame_cfg_q.parity    <= parity_mode_e'(dbus_i[5:4]);
					frame_cfg_q.two_stop  <= dbus_i[3];
					frame_cfg_q.char_size <= dbus_i[2:1];
				end
				SEL_UBRRH: ubrrh_stage_q <= dbus_i[`USART_BAUD_W-`USART_DATA_W-1:0];
				SEL_UBRRL: ubrr_q <= {ubrrh_stage_q, dbus_i}; // Whole divisor at once
				default: ;
			endcase
		end
	end

	// TXC clears on its acknowledge or on writing a one to it
	assign txc_clr = (irqack_i && (irqack_addr_i == `USART_TXC_VEC)) ||
		(ramwe_i && (sel == SEL_UCSRA) && dbus_i[6]);

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset)
			txc_q <= 1'b0;
		else if (tx_done_i)
			txc_q <= 1'b1; // A fresh completion beats a clear
		else if (txc_clr)
			txc_q <= 1'b0;
	end

	assign tx_push_o   = ramwe_i && (sel == SEL_UDR) && frame_cfg_q.tx_en;
	assign rx_pop_o    = ramre_i && (sel == SEL_UDR) && frame_cfg_q.rx_en;
	assign tx_data_o   = dbus_i;
	assign frame_cfg_o = frame_cfg_q;
	assign baud_div_o  = ubrr_q;
	assign irq_en_o    = irq_en_q;
	assign reg_sel_o   = sel;
	assign txc_flag_o  = txc_q;

	// Bus never reads and writes UDR in the same cycle
	assert property (@(posedge cp2) disable iff (!ireset) !(tx_push_o && rx_pop_o))
		else $error("UDR push and pop in the same cycle");

endmodule

// ==== src/avr_usart_pkg.sv ====
`include "avr_usart_cfg.svh"

package avr_usart_pkg;

	typedef logic [`USART_ADDR_W-1:0] ram_addr_t;
	typedef logic [`USART_DATA_W-1:0] data_t;
	typedef logic [`USART_BAUD_W-1:0] baud_div_t;
	typedef logic [`USART_VEC_W-1:0]  irq_vec_t;
	typedef logic [1:0]               char_size_t; // 0..3 gives 5..8 data bits

	// UPM field, code 01 is reserved and acts as none
	typedef enum logic [1:0] {
		PAR_NONE = 2'b00,
		PAR_EVEN = 2'b10,
		PAR_ODD  = 2'b11
	} parity_mode_e;

	typedef enum logic [2:0] {
		SEL_NONE,
		SEL_UDR,
		SEL_UCSRA,
		SEL_UCSRB,
		SEL_UCSRC,
		SEL_UBRRH,
		SEL_UBRRL
	} reg_sel_e;

	typedef enum logic {
		TX_IDLE,
		TX_SHIFT
	} tx_state_e;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA
	} rx_state_e;

	typedef struct packed {
		logic         rx_en;
		logic         tx_en;
		char_size_t   char_size;
		parity_mode_e parity;
		logic         two_stop;
	} frame_cfg_t;

	typedef struct packed {
		logic  fe;
		logic  pe;
		data_t data;
	} rx_entry_t;

	typedef struct packed {
		logic rxc;
		logic txc;
		logic udre;
	} irq_en_t;

endpackage

// ==== src/avr_usart_cfg.svh ====
`ifndef AVR_USART_CFG_SVH
`define AVR_USART_CFG_SVH

// Register addresses on the data memory bus
`define USART_UDR_ADDR    12'h0C6
`define USART_UCSRA_ADDR  12'h0C0
`define USART_UCSRB_ADDR  12'h0C1
`define USART_UCSRC_ADDR  12'h0C2
`define USART_UBRRH_ADDR  12'h0C5
`define USART_UBRRL_ADDR  12'h0C4

// Interrupt vectors
`define USART_RXC_VEC     6'h12
`define USART_UDRE_VEC    6'h13
`define USART_TXC_VEC     6'h14

`define USART_ADDR_W      12
`define USART_DATA_W      8
`define USART_BAUD_W      12
`define USART_VEC_W       6

`define USART_OVERSAMPLE  16 // Baud ticks per bit
`define USART_RX_DEPTH    2  // Receive FIFO entries

`endif
